// ==== src/stackPkg.sv ====
`default_nettype none

package stackPkg;

        // command code sampled by the stack on every rising clock edge
        typedef enum logic [1:0] {
                cmdNop  = 2'd0,
                cmdPush = 2'd1,
                cmdPop  = 2'd2,
                cmdPeek = 2'd3
        } stackCmd;

        // number of slots in the ring
        localparam int defaultDepth = 5;

        // width of one stored word
        localparam int defaultDataWidth = 4;

        // width of the peek index, taken modulo the depth
        localparam int defaultIndexWidth = 3;

endpackage

`default_nettype wire

// ==== src/ringPointer.sv ====
`default_nettype none

module ringPointer
        import stackPkg::*;
#(
        parameter int Depth = defaultDepth
) (
        input  wire logic             clk,
        input  wire logic             arstN,
        input  wire logic             writeEn,
        input  wire logic             popEn,
        output logic      [Depth-1:0] writeSel
);

        logic [Depth-1:0] pointer;
        logic [Depth-1:0] stepForward;
        logic [Depth-1:0] stepBack;

        // bit i marks the slot that the next push will write
        assign stepForward = {pointer[Depth-2:0], pointer[Depth-1]};
        assign stepBack    = {pointer[0], pointer[Depth-1:1]};

        always_ff @(posedge clk or negedge arstN) begin
                if (!arstN) begin
                        pointer <= Depth'(1);
                end else if (writeEn) begin
                        pointer <= stepForward;
                end else if (popEn) begin
                        // the popped slot keeps its word and is simply reused
                        pointer <= stepBack;
                end
        end

        assign writeSel = pointer;

        pointerOneHot: assert property (
                @(posedge clk) disable iff (!arstN)
                $onehot(writeSel)
        );

endmodule

`default_nettype wire

// ==== src/offsetSelect.sv ====
`default_nettype none

module offsetSelect
        import stackPkg::*;
#(
        parameter int Depth = defaultDepth
) (
        input  wire logic [Depth-1:0]         writeSel,
        input  wire logic [$clog2(Depth)-1:0] readOffset,
        output logic      [Depth-1:0]         readSel
);

        int unsigned shift;

        // the top sits one slot behind the write pointer
        assign shift = (32'(readOffset) + 32'd1) % 32'(Depth);

        // slot i is read when the write pointer lies shift places ahead of it
        always_comb begin
                readSel = '0;
                for (int i = 0; i < Depth; i++) begin
                        readSel[i] = writeSel[(i + int'(shift)) % Depth];
                end
        end

        always_comb begin
                readOneHot: assert final (!$onehot(writeSel) || $onehot(readSel));
        end

endmodule

`default_nettype wire

// ==== src/slotMemory.sv ====
`default_nettype none

module slotMemory
        import stackPkg::*;
#(
        parameter int Depth     = defaultDepth,
        parameter int DataWidth = defaultDataWidth
) (
        input  wire logic                 clk,
        input  wire logic                 arstN,
        input  wire logic                 writeEn,
        input  wire logic [Depth-1:0]     writeSel,
        input  wire logic [DataWidth-1:0] dataIn,
        input  wire logic [Depth-1:0]     readSel,
        output logic      [DataWidth-1:0] readWord
);

        logic [DataWidth-1:0] slots [Depth];

        // the stack starts out as all zero words
        always_ff @(posedge clk or negedge arstN) begin
                if (!arstN) begin
                        for (int i = 0; i < Depth; i++) begin
                                slots[i] <= '0;
                        end
                end else if (writeEn) begin
                        for (int i = 0; i < Depth; i++) begin
                                if (writeSel[i]) begin
                                        slots[i] <= dataIn;
                                end
                        end
                end
        end

        // and-or mux where only one select bit is ever set
        always_comb begin
                readWord = '0;
                for (int i = 0; i < Depth; i++) begin
                        readWord = readWord | (slots[i] & {DataWidth{readSel[i]}});
                end
        end

endmodule

`default_nettype wire

// ==== src/stackControl.sv ====
`default_nettype none

module stackControl
        import stackPkg::*;
#(
        parameter int Depth      = defaultDepth,
        parameter int DataWidth  = defaultDataWidth,
        parameter int IndexWidth = defaultIndexWidth
) (
        input  wire logic                           clk,
        input  wire logic                           arstN,
        input  wire stackCmd                        cmd,
        input  wire logic [IndexWidth-1:0]          index,
        input  wire logic [DataWidth-1:0]           readWord,
        output logic                                writeEn,
        output logic                                popEn,
        output logic      [$clog2(Depth)-1:0]       readOffset,
        output logic      [DataWidth-1:0]           dataOut,
        output logic                                dataValid
);

        localparam int OffsetWidth = $clog2(Depth);

        logic        readEn;
        logic [31:0] indexWide;
        logic [31:0] indexMod;

        // the index is widened first so any Depth fits the modulo
        assign indexWide = 32'(index);
        assign indexMod  = indexWide % 32'(Depth);

        always_comb begin
                writeEn    = 1'b0;
                popEn      = 1'b0;
                readEn     = 1'b0;
                readOffset = '0;
                unique case (cmd)
                        cmdPush: begin
                                writeEn = 1'b1;
                        end
                        cmdPop: begin
                                // a pop reads the top, so the offset stays zero
                                popEn  = 1'b1;
                                readEn = 1'b1;
                        end
                        cmdPeek: begin
                                readEn     = 1'b1;
                                readOffset = OffsetWidth'(indexMod);
                        end
                        default: begin
                                readEn = 1'b0;
                        end
                endcase
        end

        // each read command yields one result that is valid for a single cycle
        always_ff @(posedge clk or negedge arstN) begin
                if (!arstN) begin
                        dataOut   <= '0;
                        dataValid <= 1'b0;
                end else begin
                        dataValid <= readEn;
                        if (readEn) begin
                                dataOut <= readWord;
                        end
                end
        end

        validFollowsRead: assert property (
                @(posedge clk) disable iff (!arstN)
                dataValid |-> $past(cmd == cmdPop || cmd == cmdPeek)
        );

endmodule

`default_nettype wire

// ==== src/stackTop.sv ====
`default_nettype none

module stackTop
        import stackPkg::*;
#(
        parameter int Depth      = defaultDepth,
        parameter int DataWidth  = defaultDataWidth,
        parameter int IndexWidth = defaultIndexWidth
) (
        input  wire logic                  clk,
        input  wire logic                  arstN,
        input  wire stackCmd               cmd,
        input  wire logic [IndexWidth-1:0] index,
        input  wire logic [DataWidth-1:0]  dataIn,
        output logic      [DataWidth-1:0]  dataOut,
        output logic                       dataValid
);

        // a read offset is always reduced below Depth
        localparam int OffsetWidth = $clog2(Depth);

        logic                   writeEn;
        logic                   popEn;
        logic [OffsetWidth-1:0] readOffset;
        logic [Depth-1:0]       writeSel;
        logic [Depth-1:0]       readSel;
        logic [DataWidth-1:0]   readWord;

        stackControl #(
                .Depth      (Depth),
                .DataWidth  (DataWidth),
                .IndexWidth (IndexWidth)
        ) control_i (
                .clk        (clk),
                .arstN      (arstN),
                .cmd        (cmd),
                .index      (index),
                .readWord   (readWord),
                .writeEn    (writeEn),
                .popEn      (popEn),
                .readOffset (readOffset),
                .dataOut    (dataOut),
                .dataValid  (dataValid)
        );

        ringPointer #(
                .Depth    (Depth)
        ) pointer_i (
                .clk      (clk),
                .arstN    (arstN),
                .writeEn  (writeEn),
                .popEn    (popEn),
                .writeSel (writeSel)
        );

        offsetSelect #(
                .Depth      (Depth)
        ) select_i (
                .writeSel   (writeSel),
                .readOffset (readOffset),
                .readSel    (readSel)
        );

        slotMemory #(
                .Depth     (Depth),
                .DataWidth (DataWidth)
        ) memory_i (
                .clk       (clk),
                .arstN     (arstN),
                .writeEn   (writeEn),
                .writeSel  (writeSel),
                .dataIn    (dataIn),
                .readSel   (readSel),
                .readWord  (readWord)
        );

endmodule

`default_nettype wire

// ==== bench/stackChecks.svh ====
`ifndef STACK_CHECKS_SVH
`define STACK_CHECKS_SVH

        // the reference stack keeps a ring of words and the slot the next push fills
        logic [DataWidth-1:0] modelSlots [Depth];
        int                   modelPos;

        function automatic void modelReset();
                for (int i = 0; i < Depth; i++) begin
                        modelSlots[i] = '0;
                end
                modelPos = 0;
        endfunction

        function automatic void modelPush(input logic [DataWidth-1:0] word);
                modelSlots[SlotBits'(modelPos)] = word;
                modelPos = (modelPos + 1) % Depth;
        endfunction

        // the popped word stays in its slot
        function automatic logic [DataWidth-1:0] modelPop();
                modelPos = (modelPos + Depth - 1) % Depth;
                return modelSlots[SlotBits'(modelPos)];
        endfunction

        function automatic logic [DataWidth-1:0] modelPeek(input logic [IndexWidth-1:0] idx);
                int behind;
                behind = 1 + (int'(idx) % Depth);
                return modelSlots[SlotBits'((modelPos + Depth - behind) % Depth)];
        endfunction

        function automatic logic [31:0] xorshift32(input logic [31:0] x);
                logic [31:0] y;
                y = x ^ (x << 13);
                y = y ^ (y >> 17);
                y = y ^ (y << 5);
                return y;
        endfunction

        function automatic void noteError();
                errorCount++;
                testErrors++;
        endfunction

        task automatic checkWord(input string name, input logic [DataWidth-1:0] expected,
                                 input logic [DataWidth-1:0] actual);
                if (actual !== expected) begin
                        $display("Mismatch in %s: expected %h, actual %h", name, expected, actual);
                        noteError();
                end
        endtask

        task automatic checkValid(input string name, input logic expected, input logic actual);
                if (actual !== expected) begin
                        $display("Mismatch in %s: expected dataValid %b, actual %b",
                                 name, expected, actual);
                        noteError();
                end
        endtask

`endif

// ==== bench/stackTb.sv ====
`default_nettype none

module stackTb
        import stackPkg::*;
();

        timeunit 1ns;
        timeprecision 100ps;

        localparam int Depth        = defaultDepth;
        localparam int DataWidth    = defaultDataWidth;
        localparam int IndexWidth   = defaultIndexWidth;
        localparam int SlotBits     = $clog2(Depth);
        localparam int ValidTimeout = 8;
        localparam int RandomSteps  = 40;

        typedef struct {
                string                 name;
                stackCmd               cmd;
                logic [IndexWidth-1:0] index;
                logic [DataWidth-1:0]  data;
        } stepEntry;

        logic                  clk;
        logic                  arstN;
        stackCmd               cmd;
        logic [IndexWidth-1:0] index;
        logic [DataWidth-1:0]  dataIn;
        logic [DataWidth-1:0]  dataOut;
        logic                  dataValid;

        stepEntry    steps [$];
        int          errorCount;
        int          testErrors;
        int          testsRun;
        int          testsFailed;
        logic [31:0] rngState;

        `include "stackChecks.svh"

        stackTop #(
                .Depth      (Depth),
                .DataWidth  (DataWidth),
                .IndexWidth (IndexWidth)
        ) dut_i (
                .clk        (clk),
                .arstN      (arstN),
                .cmd        (cmd),
                .index      (index),
                .dataIn     (dataIn),
                .dataOut    (dataOut),
                .dataValid  (dataValid)
        );

        initial begin
                clk = 1'b0;
                forever #4 clk = ~clk;
        end

        task automatic addStep(input string name, input stackCmd c,
                               input logic [IndexWidth-1:0] idx, input logic [DataWidth-1:0] data);
                stepEntry s;
                s.name  = name;
                s.cmd   = c;
                s.index = idx;
                s.data  = data;
                steps.push_back(s);
        endtask

        task automatic buildTable();
                logic [31:0] r;
                logic [DataWidth-1:0] pushWords [6];
                pushWords = '{4'h9, 4'hC, 4'h7, 4'hE, 4'h2, 4'hB};
                addStep("reset", cmdNop, 3'd0, 4'h0);
                addStep("reset", cmdPop, 3'd0, 4'h0);
                addStep("reset", cmdNop, 3'd0, 4'h0);
                addStep("order", cmdPush, 3'd0, 4'h3);
                addStep("order", cmdPush, 3'd0, 4'hA);
                addStep("order", cmdPush, 3'd0, 4'h5);
                for (int i = 0; i < 3; i++) begin
                        addStep("order", cmdPop, 3'd0, 4'h0);
                end
                // the sixth push lands on the slot of the first
                for (int i = 0; i < 6; i++) begin
                        addStep("overflow", cmdPush, 3'd0, pushWords[i]);
                end
                for (int i = 0; i < 5; i++) begin
                        addStep("overflow", cmdPeek, IndexWidth'(i), 4'h0);
                end
                for (int i = 5; i < 8; i++) begin
                        addStep("indexWrap", cmdPeek, IndexWidth'(i), 4'h0);
                end
                addStep("popPeek", cmdPop, 3'd0, 4'h0);
                addStep("popPeek", cmdPop, 3'd0, 4'h0);
                addStep("popPeek", cmdPeek, 3'd0, 4'h0);
                addStep("popPeek", cmdPush, 3'd0, 4'h6);
                addStep("popPeek", cmdPush, 3'd0, 4'hD);
                addStep("popPeek", cmdPeek, 3'd0, 4'h0);
                addStep("popPeek", cmdPeek, 3'd1, 4'h0);
                addStep("popPeek", cmdPop, 3'd0, 4'h0);
                for (int i = 0; i < RandomSteps; i++) begin
                        rngState = xorshift32(rngState);
                        r = rngState;
                        addStep("randomRun", stackCmd'(r[1:0]), r[6:4], r[11:8]);
                end
        endtask

        // drives one step and checks the response at the edge that samples it
        task automatic applyStep(input stepEntry s);
                logic [DataWidth-1:0] expected;
                int waited;
                expected = '0;
                waited = 0;
                cmd    = s.cmd;
                index  = s.index;
                dataIn = s.data;
                @(posedge clk);
                #1;
                case (s.cmd)
                        cmdPush: modelPush(s.data);
                        cmdPop:  expected = modelPop();
                        cmdPeek: expected = modelPeek(s.index);
                        default: expected = '0;
                endcase
                if (s.cmd == cmdPop || s.cmd == cmdPeek) begin
                        if (!dataValid) begin
                                cmd = cmdNop;
                        end
                        while (!dataValid && waited < ValidTimeout) begin
                                @(posedge clk);
                                #1;
                                waited++;
                        end
                        if (!dataValid) begin
                                $display("%s: no valid read word within %0d cycles of the command",
                                         s.name, ValidTimeout);
                                noteError();
                        end else begin
                                if (waited != 0) begin
                                        $display("%s: read word arrived %0d cycles late",
                                                 s.name, waited);
                                        noteError();
                                end
                                checkWord(s.name, expected, dataOut);
                        end
                end else begin
                        checkValid(s.name, 1'b0, dataValid);
                end
        endtask

        task automatic finishTest(input string name);
                testsRun++;
                if (testErrors == 0) begin
                        $display("test %s: ok", name);
                end else begin
                        testsFailed++;
                        $display("test %s: %0d errors", name, testErrors);
                end
                testErrors = 0;
        endtask

        initial begin
                cmd         = cmdNop;
                index       = '0;
                dataIn      = '0;
                arstN       = 1'b0;
                errorCount  = 0;
                testErrors  = 0;
                testsRun    = 0;
                testsFailed = 0;
                rngState    = 32'd14;
                modelReset();
                buildTable();
                repeat (2) @(posedge clk);
                #1 arstN = 1'b1;
                for (int i = 0; i < steps.size(); i++) begin
                        applyStep(steps[i]);
                        if (i == steps.size() - 1 || steps[i + 1].name != steps[i].name) begin
                                finishTest(steps[i].name);
                        end
                end
                cmd = cmdNop;
                $display("%0d tests run, %0d with errors, %0d errors in total",
                         testsRun, testsFailed, errorCount);
                if (errorCount == 0) begin
                        $display("all tests passed");
                end else begin
                        $display("tests failed");
                end
                $finish;
        end

endmodule

`default_nettype wire

// ==== stack.f ====
+incdir+bench
src/stackPkg.sv
src/ringPointer.sv
src/offsetSelect.sv
src/slotMemory.sv
src/stackControl.sv
src/stackTop.sv
bench/stackTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# builds the stack testbench with Verilator, runs it and judges the log

set -u
cd "$(dirname "$0")" || exit 1

buildDir=obj_dir
logFile=sim.log

verilator --binary --timing --assert -f stack.f --top-module stackTb \
        -Mdir "$buildDir" -o stackSim
if [ $? -ne 0 ]; then
        echo "verilator build failed"
        exit 1
fi

"./$buildDir/stackSim" > "$logFile" 2>&1
simStatus=$?
cat "$logFile"
if [ $simStatus -ne 0 ]; then
        echo "simulation exited with status $simStatus"
        exit 1
fi

# the testbench prints its fail message whenever any check went wrong
if grep -q "tests failed" "$logFile"; then
        exit 1
fi

exit 0
